// ==== logic/ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// register word, also used for pc and jump targets
`define XLEN      32

`define REG_AW    5

// one quotient bit per divider iteration
`define DIV_STEPS 32

`endif

// ==== logic/rv_isa_pkg.sv ====
`include "ex_params.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] xword_t;

    // major opcodes handled by the execute stage
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SR      = 3'b101,  // srl or sra, picked by inst[30]
        OR      = 3'b110,
        AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_f3_e;

    // funct3[2] splits multiply from divide
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } md_op_e;

    localparam logic [6:0] FUNCT7_M = 7'b0000001;

endpackage

// ==== logic/ex_if_pkg.sv ====
`include "ex_params.svh"

package ex_if_pkg;

    import rv_isa_pkg::*;

    // one decoded instruction with its operands
    typedef struct packed {
        logic [31:0]         inst;
        xword_t              pc;
        logic                compressed;  // 16-bit encoding, links to pc+2
        xword_t              op1;
        xword_t              op2;
        xword_t              rs1_data;    // compare inputs for branches
        xword_t              rs2_data;
        logic [`REG_AW-1:0]  rd;
        logic                reg_we;
    } ex_req_t;

    typedef struct packed {
        logic                reg_we;
        logic [`REG_AW-1:0]  rd;
        xword_t              wdata;
        logic                jump;
        xword_t              jump_addr;
    } ex_rsp_t;

    // operands for the multiplier and the divider
    typedef struct packed {
        md_op_e  op;
        xword_t  a;
        xword_t  b;
    } md_req_t;

endpackage

// ==== logic/mult.sv ====
`include "ex_params.svh"

module mult
    import rv_isa_pkg::*;
    import ex_if_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  logic             req_i,
    input  md_req_t          data_i,
    output logic             ack_o,
    output logic [`XLEN-1:0] result_o
);

    logic                      req_q;
    logic                      busy;
    logic                      a_signed;
    logic                      b_signed;
    md_op_e                    op_q;
    logic signed [`XLEN:0]     a_q;  // one extra bit carries the sign or a zero
    logic signed [`XLEN:0]     b_q;
    logic signed [2*`XLEN-1:0] prod;

    assign a_signed = data_i.op inside {MULH, MULHSU};
    assign b_signed = data_i.op == MULH;

    assign prod = a_q * b_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
            busy  <= 1'b0;
            ack_o <= 1'b0;
        end else begin
            req_q <= req_i;
            if (busy) begin
                busy  <= 1'b0;
                ack_o <= 1'b1;
            end else if (req_q && !ack_o) begin
                busy <= 1'b1;
            end else if (ack_o && !req_q) begin
                ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_q && !busy && !ack_o) begin
            op_q <= data_i.op;
            a_q  <= {a_signed & data_i.a[`XLEN-1], data_i.a};
            b_q  <= {b_signed & data_i.b[`XLEN-1], data_i.b};
        end
        if (busy) begin
            result_o <= (op_q == MUL) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];  // high word
        end
    end

    // ack only after a request held over the load and product cycles
    a_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> ($past(req_i, 1) && $past(req_i, 2)));

endmodule

// ==== logic/div.sv ====
`include "ex_params.svh"

module div
    import rv_isa_pkg::*;
    import ex_if_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_n_i,

    input  logic             req_i,
    input  md_req_t          data_i,
    output logic             ack_o,
    output logic [`XLEN-1:0] result_o
);

    localparam int CNT_W = $clog2(`DIV_STEPS + 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX,
        DONE
    } div_state_e;

    div_state_e       state;
    logic             req_q;
    logic [CNT_W-1:0] cnt;

    md_op_e           op_q;
    logic [`XLEN-1:0] quo;    // dividend shifts out as quotient shifts in
    logic [`XLEN-1:0] rem;
    logic [`XLEN-1:0] dvs;
    logic [`XLEN-1:0] dvd_q;  // raw dividend, remainder on zero divisor
    logic             neg_q;
    logic             neg_r;
    logic             dvs_zero;

    logic             is_signed;
    logic             a_neg;
    logic             b_neg;
    logic [`XLEN:0]   rem_sh;
    logic [`XLEN:0]   rem_sub;
    logic             fits;
    logic [`XLEN-1:0] q_fix;
    logic [`XLEN-1:0] r_fix;

    assign is_signed = data_i.op inside {DIV, REM};
    assign a_neg     = is_signed & data_i.a[`XLEN-1];
    assign b_neg     = is_signed & data_i.b[`XLEN-1];

    // trial subtract of one restoring step
    assign rem_sh  = {rem, quo[`XLEN-1]};
    assign rem_sub = rem_sh - {1'b0, dvs};
    assign fits    = !rem_sub[`XLEN];

    // most negative / -1 comes out right from the magnitudes alone
    assign q_fix = dvs_zero ? {`XLEN{1'b1}} : (neg_q ? -quo : quo);
    assign r_fix = dvs_zero ? dvd_q : (neg_r ? -rem : rem);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
            req_q <= 1'b0;
            cnt   <= '0;
            ack_o <= 1'b0;
        end else begin
            req_q <= req_i;
            case (state)
                IDLE: begin
                    if (req_q) begin
                        cnt   <= '0;
                        state <= RUN;
                    end
                end
                RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(`DIV_STEPS - 1)) state <= FIX;
                end
                FIX: begin
                    ack_o <= 1'b1;
                    state <= DONE;
                end
                DONE: begin
                    if (!req_q) begin
                        ack_o <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == IDLE && req_q) begin
            op_q     <= data_i.op;
            quo      <= a_neg ? -data_i.a : data_i.a;
            dvs      <= b_neg ? -data_i.b : data_i.b;
            rem      <= '0;
            dvd_q    <= data_i.a;
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;  // remainder takes the dividend sign
            dvs_zero <= data_i.b == '0;
        end
        if (state == RUN) begin
            quo <= {quo[`XLEN-2:0], fits};
            rem <= fits ? rem_sub[`XLEN-1:0] : rem_sh[`XLEN-1:0];
        end
        if (state == FIX) begin
            result_o <= (op_q inside {DIV, DIVU}) ? q_fix : r_fix;
        end
    end

    a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cnt <= CNT_W'(`DIV_STEPS));

endmodule

// ==== logic/ex.sv ====
`include "ex_params.svh"

module ex
    import rv_isa_pkg::*;
    import ex_if_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_n_i,

    input  logic    req_i,
    input  ex_req_t req_data_i,
    output logic    ack_o,
    output ex_rsp_t rsp_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_MD,
        ACK
    } ex_state_e;

    ex_state_e state;
    logic      req_q;

    opcode_e   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_f3_e   alu_f3;
    br_f3_e    br_f3;
    md_op_e    md_op;
    logic      is_md;
    logic      is_div;

    xword_t    op1;
    xword_t    op2;
    logic [4:0] shamt;
    logic      sub;
    xword_t    sum;
    xword_t    srl_res;
    xword_t    sr_mask;
    xword_t    sra_res;
    xword_t    cmp_a;
    xword_t    cmp_b;
    logic      lt_s;
    logic      lt_u;
    logic      eq;
    logic      taken;
    xword_t    link;
    ex_rsp_t   rsp_d;

    md_req_t   md_data;
    logic      mult_req;
    logic      mult_ack;
    logic      div_req;
    logic      div_ack;
    logic [`XLEN-1:0] mult_result;
    logic [`XLEN-1:0] div_result;

    assign opcode = opcode_e'(req_data_i.inst[6:0]);
    assign funct3 = req_data_i.inst[14:12];
    assign funct7 = req_data_i.inst[31:25];
    assign alu_f3 = alu_f3_e'(funct3);
    assign br_f3  = br_f3_e'(funct3);
    assign md_op  = md_op_e'(funct3);
    assign is_md  = (opcode == OP_REG) && (funct7 == FUNCT7_M);
    assign is_div = is_md && (md_op inside {DIV, DIVU, REM, REMU});

    assign op1   = req_data_i.op1;
    assign op2   = req_data_i.op2;
    assign shamt = op2[4:0];  // also inst[24:20] for the immediate shifts

    // one adder for add, sub, branch and jump targets, lui and auipc
    assign sub = (opcode == OP_REG) && req_data_i.inst[30];
    assign sum = op1 + (sub ? ~op2 : op2) + {{(`XLEN-1){1'b0}}, sub};

    // sra as logical shift plus sign fill above the mask
    assign srl_res = op1 >> shamt;
    assign sr_mask = {`XLEN{1'b1}} >> shamt;
    assign sra_res = srl_res | ({`XLEN{op1[`XLEN-1]}} & ~sr_mask);

    assign cmp_a = (opcode == OP_BRANCH) ? req_data_i.rs1_data : op1;
    assign cmp_b = (opcode == OP_BRANCH) ? req_data_i.rs2_data : op2;
    assign lt_s  = $signed(cmp_a) < $signed(cmp_b);
    assign lt_u  = cmp_a < cmp_b;
    assign eq    = cmp_a == cmp_b;

    assign link = req_data_i.pc + (req_data_i.compressed ? `XLEN'd2 : `XLEN'd4);

    always_comb begin
        rsp_d        = '0;
        rsp_d.reg_we = req_data_i.reg_we;
        rsp_d.rd     = req_data_i.rd;
        taken        = 1'b0;
        case (opcode)
            OP_IMM, OP_REG: begin
                if (is_md) begin
                    rsp_d.wdata = is_div ? div_result : mult_result;
                end else begin
                    case (alu_f3)
                        ADD_SUB: rsp_d.wdata = sum;
                        SLL:     rsp_d.wdata = op1 << shamt;
                        SLT:     rsp_d.wdata = {{(`XLEN-1){1'b0}}, lt_s};
                        SLTU:    rsp_d.wdata = {{(`XLEN-1){1'b0}}, lt_u};
                        XOR:     rsp_d.wdata = op1 ^ op2;
                        SR:      rsp_d.wdata = req_data_i.inst[30] ? sra_res : srl_res;
                        OR:      rsp_d.wdata = op1 | op2;
                        AND:     rsp_d.wdata = op1 & op2;
                    endcase
                end
            end
            OP_BRANCH: begin
                rsp_d.reg_we = 1'b0;
                case (br_f3)
                    BEQ:     taken = eq;
                    BNE:     taken = !eq;
                    BLT:     taken = lt_s;
                    BGE:     taken = !lt_s;
                    BLTU:    taken = lt_u;
                    BGEU:    taken = !lt_u;
                    default: taken = 1'b0;
                endcase
                rsp_d.jump      = taken;
                rsp_d.jump_addr = taken ? sum : '0;
            end
            OP_JAL, OP_JALR: begin
                rsp_d.wdata     = link;
                rsp_d.jump      = 1'b1;
                rsp_d.jump_addr = sum;
            end
            OP_LUI, OP_AUIPC: rsp_d.wdata = sum;
            default: rsp_d.reg_we = 1'b0;  // not handled here
        endcase
    end

    assign md_data = '{op: md_op, a: op1, b: op2};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= IDLE;
            req_q    <= 1'b0;
            ack_o    <= 1'b0;
            mult_req <= 1'b0;
            div_req  <= 1'b0;
            rsp_o    <= '0;
        end else begin
            req_q <= req_i;
            case (state)
                IDLE: begin
                    if (req_q) begin
                        if (is_md) begin
                            mult_req <= !is_div;
                            div_req  <= is_div;
                            state    <= WAIT_MD;
                        end else begin
                            rsp_o <= rsp_d;
                            ack_o <= 1'b1;
                            state <= ACK;
                        end
                    end
                end
                WAIT_MD: begin
                    if ((mult_req && mult_ack) || (div_req && div_ack)) begin
                        rsp_o    <= rsp_d;
                        ack_o    <= 1'b1;
                        mult_req <= 1'b0;
                        div_req  <= 1'b0;
                        state    <= ACK;
                    end
                end
                ACK: begin
                    if (!req_q) begin
                        ack_o <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    mult u_mult (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (mult_req),
        .data_i  (md_data),
        .ack_o   (mult_ack),
        .result_o(mult_result)
    );

    div u_div (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (div_req),
        .data_i  (md_data),
        .ack_o   (div_ack),
        .result_o(div_result)
    );

    // requester keeps req up until it has seen ack
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (req_i && !ack_o) |=> (req_i || ack_o));

    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> (!ack_o || $stable(rsp_o)));

endmodule

// ==== sim/ex_tb.sv ====
`include "ex_params.svh"

module ex_tb
    import rv_isa_pkg::*;
    import ex_if_pkg::*;
;

    localparam int TIMEOUT = 100;  // cycles per handshake phase

    logic    clk_i;
    logic    rst_n_i;
    logic    req_i;
    ex_req_t req_data_i;
    logic    ack_o;
    ex_rsp_t rsp_o;

    int          check_errors;
    int          timeouts;
    logic [31:0] lcg_state;

    ex UUT (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .req_data_i(req_data_i),
        .ack_o     (ack_o),
        .rsp_o     (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // corner operands for mult and div
    function automatic logic [31:0] edge_val(int i);
        case (i)
            0:       return 32'h8000_0000;
            1:       return 32'hffff_ffff;
            2:       return 32'h0000_0000;
            3:       return 32'h7fff_ffff;
            4:       return 32'hffff_fff9;
            default: return 32'd3;
        endcase
    endfunction

    function automatic logic [31:0] md_model(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        logic               sign_a;
        logic               sign_b;
        logic [63:0]        p;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic               ovf;
        logic [31:0]        res;
        sign_a = (f3 == 3'd1 || f3 == 3'd2) && a[31];
        sign_b = (f3 == 3'd1) && b[31];
        p      = {{32{sign_a}}, a} * {{32{sign_b}}, b};  // low 64 bits of the wide product
        sa     = a;
        sb     = b;
        ovf    = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (f3)
            3'd0: res = p[31:0];
            3'd1, 3'd2, 3'd3: res = p[63:32];
            3'd4: begin
                if (b == 0) res = 32'hffff_ffff;
                else if (ovf) res = a;
                else res = sa / sb;
            end
            3'd5: res = (b == 0) ? 32'hffff_ffff : a / b;
            3'd6: begin
                if (b == 0) res = a;
                else if (ovf) res = 32'd0;
                else res = sa % sb;
            end
            default: res = (b == 0) ? a : a % b;
        endcase
        return res;
    endfunction

    function automatic ex_rsp_t ref_model(ex_req_t r);
        ex_rsp_t            e;
        logic [6:0]         opc;
        logic [2:0]         f3;
        logic [6:0]         f7;
        logic [4:0]         sh;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic signed [31:0] s1;
        logic signed [31:0] s2;
        logic               taken;
        opc      = r.inst[6:0];
        f3       = r.inst[14:12];
        f7       = r.inst[31:25];
        sh       = r.op2[4:0];
        sa       = r.op1;
        sb       = r.op2;
        s1       = r.rs1_data;
        s2       = r.rs2_data;
        taken    = 1'b0;
        e        = '0;
        e.reg_we = r.reg_we;
        e.rd     = r.rd;
        case (opc)
            OP_IMM, OP_REG: begin
                if (opc == OP_REG && f7 == FUNCT7_M) begin
                    e.wdata = md_model(f3, r.op1, r.op2);
                end else begin
                    case (f3)
                        3'b000: e.wdata = (opc == OP_REG && f7[5]) ? r.op1 - r.op2
                                                                   : r.op1 + r.op2;
                        3'b001: e.wdata = r.op1 << sh;
                        3'b010: e.wdata = (sa < sb) ? 32'd1 : 32'd0;
                        3'b011: e.wdata = (r.op1 < r.op2) ? 32'd1 : 32'd0;
                        3'b100: e.wdata = r.op1 ^ r.op2;
                        3'b101: begin
                            if (f7[5]) e.wdata = sa >>> sh;
                            else e.wdata = r.op1 >> sh;
                        end
                        3'b110: e.wdata = r.op1 | r.op2;
                        default: e.wdata = r.op1 & r.op2;
                    endcase
                end
            end
            OP_BRANCH: begin
                e.reg_we = 1'b0;
                case (f3)
                    3'b000: taken = r.rs1_data == r.rs2_data;
                    3'b001: taken = r.rs1_data != r.rs2_data;
                    3'b100: taken = s1 < s2;
                    3'b101: taken = s1 >= s2;
                    3'b110: taken = r.rs1_data < r.rs2_data;
                    3'b111: taken = r.rs1_data >= r.rs2_data;
                    default: taken = 1'b0;
                endcase
                e.jump = taken;
                if (taken) e.jump_addr = r.op1 + r.op2;
            end
            OP_JAL, OP_JALR: begin
                e.wdata     = r.pc + (r.compressed ? 32'd2 : 32'd4);
                e.jump      = 1'b1;
                e.jump_addr = r.op1 + r.op2;
            end
            OP_LUI, OP_AUIPC: e.wdata = r.op1 + r.op2;
            default: e.reg_we = 1'b0;
        endcase
        return e;
    endfunction

    function automatic ex_req_t make_req(logic [6:0] opc, logic [2:0] f3, logic [6:0] f7,
                                         logic [31:0] a, logic [31:0] b);
        ex_req_t     r;
        logic [31:0] pc;
        r          = '0;
        pc         = next_rand();
        r.pc       = {pc[31:2], 2'b00};
        r.rd       = 5'(next_rand() % 31 + 1);
        r.inst     = {f7, 5'd2, 5'd1, f3, r.rd, opc};
        r.op1      = a;
        r.op2      = b;
        r.rs1_data = a;
        r.rs2_data = (opc == OP_IMM) ? next_rand() : b;  // rs2 unrelated to the immediate
        r.reg_we   = 1'b1;
        return r;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic compare_rsp(input string tag, input ex_rsp_t got, input ex_rsp_t exp);
        expect_eq({tag, " reg_we"}, got.reg_we, exp.reg_we);
        expect_eq({tag, " rd"}, got.rd, exp.rd);
        if (exp.reg_we) expect_eq({tag, " wdata"}, got.wdata, exp.wdata);
        expect_eq({tag, " jump"}, got.jump, exp.jump);
        if (exp.jump) expect_eq({tag, " jump_addr"}, got.jump_addr, exp.jump_addr);
    endtask

    task automatic wait_ack(input logic level, input string what);
        int t;
        t = 0;
        while (ack_o !== level && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (ack_o !== level) begin
            $display("timeout at %0t: ack_o never went to %0b %s", $time, level, what);
            timeouts++;
        end
    endtask

    // one full four-phase transaction from a falling edge
    task automatic do_op(input string tag, input ex_req_t r);
        ex_rsp_t exp;
        exp        = ref_model(r);
        req_data_i = r;
        req_i      = 1'b1;
        wait_ack(1'b1, {"while waiting on ", tag});
        if (ack_o) compare_rsp(tag, rsp_o, exp);
        req_i = 1'b0;
        wait_ack(1'b0, {"after req_i dropped on ", tag});
    endtask

    task automatic reset_and_timing();
        ex_req_t r;
        ex_rsp_t held;
        expect_eq("ack_o after reset", ack_o, 0);
        expect_eq("rsp_o zero after reset", rsp_o == '0, 1);
        r          = make_req(OP_REG, 3'b000, 7'h00, 32'd1234, 32'd4321);
        req_data_i = r;
        req_i      = 1'b1;
        @(negedge clk_i);
        expect_eq("ack_o before its cycle", ack_o, 0);
        @(negedge clk_i);
        expect_eq("ack_o one cycle after sample", ack_o, 1);
        compare_rsp("timing add", rsp_o, ref_model(r));
        held = rsp_o;
        repeat (4) begin
            @(negedge clk_i);
            expect_eq("ack_o held", ack_o, 1);
            expect_eq("rsp_o held", rsp_o == held, 1);
        end
        req_i = 1'b0;
        @(negedge clk_i);
        expect_eq("ack_o until req_i low sampled", ack_o, 1);
        @(negedge clk_i);
        expect_eq("ack_o low after drop", ack_o, 0);
        wait_ack(1'b0, "at the end of the timing test");
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [6:0]  f7;
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int n = 0; n < 4; n++) begin
                a  = next_rand();
                b  = next_rand();
                f7 = ((f3 == 0 || f3 == 5) && n[0]) ? 7'h20 : 7'h00;  // sub and sra
                do_op("alu reg", make_req(OP_REG, f3[2:0], f7, a, b));
                imm = b[11:0];
                if (f3 == 1 || f3 == 5) imm = {f7, b[4:0]};
                do_op("alu imm", make_req(OP_IMM, f3[2:0], imm[11:5], a, sext12(imm)));
            end
        end
        do_op("sll by 0", make_req(OP_REG, 3'b001, 7'h00, 32'hdead_beef, 32'd0));
        do_op("sll by 31", make_req(OP_REG, 3'b001, 7'h00, 32'h0000_0003, 32'd31));
        do_op("srl by 31", make_req(OP_IMM, 3'b101, 7'h00, 32'h8000_0000, 32'd31));
        do_op("sra negative", make_req(OP_REG, 3'b101, 7'h20, 32'h8000_0f00, 32'd4));
        do_op("sra by 0", make_req(OP_REG, 3'b101, 7'h20, 32'hf000_0001, 32'd0));
        do_op("srai by 31", make_req(OP_IMM, 3'b101, 7'h20, 32'h8000_0000, sext12(12'h41f)));
        do_op("slt signed", make_req(OP_REG, 3'b010, 7'h00, 32'hffff_ffff, 32'd1));
        do_op("sltu unsigned", make_req(OP_REG, 3'b011, 7'h00, 32'hffff_ffff, 32'd1));
        do_op("slti signed", make_req(OP_IMM, 3'b010, 7'h7f, 32'd5, sext12(12'hfff)));
    endtask

    task automatic branch_and_jump_ops();
        ex_req_t     r;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] v;
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;
            for (int k = 0; k < 3; k++) begin
                case (k)
                    0: begin
                        x = 32'd5;
                        y = 32'd5;
                    end
                    1: begin
                        x = 32'hffff_ffff;
                        y = 32'd1;
                    end
                    default: begin
                        x = 32'd1;
                        y = 32'hffff_ffff;
                    end
                endcase
                v          = next_rand();
                r          = make_req(OP_BRANCH, f3[2:0], 7'h00, 32'd0, sext12({v[11:1], 1'b0}));
                r.op1      = r.pc;
                r.rs1_data = x;
                r.rs2_data = y;
                do_op("branch", r);
            end
        end
        for (int c = 0; c < 2; c++) begin
            v            = next_rand();
            r            = make_req(OP_JAL, 3'b000, 7'h00, 32'd0, sext12({v[11:1], 1'b0}));
            r.op1        = r.pc;
            r.compressed = c[0];
            do_op("jal", r);
            r            = make_req(OP_JALR, 3'b000, 7'h00, next_rand(), sext12(v[23:12]));
            r.compressed = c[0];
            do_op("jalr", r);
        end
        v = next_rand();
        do_op("lui", make_req(OP_LUI, 3'b000, 7'h00, 32'd0, {v[31:12], 12'h000}));
        r     = make_req(OP_AUIPC, 3'b000, 7'h00, 32'd0, {v[19:0], 12'h000});
        r.op1 = r.pc;
        do_op("auipc", r);
    endtask

    // lo selects mul ops 0..3 or div ops 4..7
    task automatic muldiv_ops(input int lo);
        for (int f3 = lo; f3 < lo + 4; f3++) begin
            for (int i = 0; i < 6; i++) begin
                for (int j = 0; j < 6; j++) begin
                    do_op("md edge",
                          make_req(OP_REG, f3[2:0], FUNCT7_M, edge_val(i), edge_val(j)));
                end
            end
            for (int n = 0; n < 6; n++) begin
                do_op("md random", make_req(OP_REG, f3[2:0], FUNCT7_M, next_rand(), next_rand()));
            end
            do_op("md small divisor", make_req(OP_REG, f3[2:0], FUNCT7_M, next_rand(),
                                               32'(next_rand() % 17)));
        end
    endtask

    task automatic unsupported_opcodes();
        do_op("load opcode", make_req(7'b0000011, 3'b010, 7'h00, next_rand(), next_rand()));
        do_op("fence opcode", make_req(7'b0001111, 3'b000, 7'h00, next_rand(), next_rand()));
    endtask

    initial begin
        check_errors = 0;
        timeouts     = 0;
        lcg_state    = 32'd73;
        rst_n_i      = 1'b0;
        req_i        = 1'b0;
        req_data_i   = '0;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        reset_and_timing();
        alu_ops();
        branch_and_jump_ops();
        muldiv_ops(0);
        muldiv_ops(4);
        unsupported_opcodes();

        $display("failed checks: %0d, handshake timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== ex.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/ex_if_pkg.sv
logic/mult.sv
logic/div.sv
logic/ex.sv
sim/ex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f ex.f --top-module ex_tb \
    -Mdir obj_dir -o ex_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/ex_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
exit 0
